/* vlog.f */
source/mips_pkg.sv
source/forwarding_unit.sv
source/instruction_fetch.sv
source/instruction_decode.sv
source/execute.sv
source/memory_access.sv
source/mips_core.sv
bench/mips_checker.sv
bench/tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - files:
      - source/mips_pkg.sv
      - source/forwarding_unit.sv
      - source/instruction_fetch.sv
      - source/instruction_decode.sv
      - source/execute.sv
      - source/memory_access.sv
      - source/mips_core.sv
  - target: test
    files:
      - bench/mips_checker.sv
      - bench/tb_mips_core.sv

/* bench/tb_mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    localparam int CLK_PERIOD      = 20;
    localparam int RST_CYCLES      = 16;
    localparam int DRIVE_DELAY     = 2;
    localparam int PROG_LEN        = 15;    // Must fit in RST_CYCLES - 1 load slots
    localparam int EXP_LEN         = 7;
    localparam int CYCLES_PER_WORD = 40;
    localparam int DRAIN_CYCLES    = 8;
    localparam int TIMEOUT_CYCLES  = PROG_LEN * CYCLES_PER_WORD + RST_CYCLES;

    // HALT is the last program word, byte address of that word
    localparam logic [mips_pkg::LEN-1:0] HALT_PC = (PROG_LEN - 1) * 4;

    int unsigned seed = 32'h9529_d3ff;

    logic                              clk;
    logic                              rst;
    logic                              load;
    logic [mips_pkg::NB_IM_ADDR-1:0]   load_addr;
    logic [mips_pkg::LEN-1:0]          load_data;
    logic [mips_pkg::LEN-1:0]          pc;
    logic                              retire_we;
    logic [mips_pkg::NB_REG_ADDR-1:0]  retire_reg;
    logic [mips_pkg::LEN-1:0]          retire_data;
    logic                              halt;
    wire  [31:0]                       error_count;
    wire  [31:0]                       retire_count;

    //////////////////////////////
    // Program and expectations
    //////////////////////////////
    logic [mips_pkg::LEN-1:0] program_words [PROG_LEN] = '{
        32'h2401_FFFB,  // ADDIU r1, r0, -5
        32'h0001_1023,  // SUBU  r2, r0, r1     EX/MEM forward
        32'h0022_182A,  // SLT   r3, r1, r2     both forwarding paths
        32'hAC02_0008,  // SW    r2, 8(r0)
        32'h8C04_0008,  // LW    r4, 8(r0)
        32'h0083_2821,  // ADDU  r5, r4, r3     load-use stall
        32'h10A2_0003,  // BEQ   r5, r2, +3     not taken
        32'h00A1_3024,  // AND   r6, r5, r1
        32'h2400_0009,  // ADDIU r0, r0, 9      no retire
        32'h0006_3825,  // OR    r7, r0, r6     r0 must read as 0
        32'h10E6_0003,  // BEQ   r7, r6, +3     taken to word 14
        32'h2409_0001,  // ADDIU r9, r0, 1      flushed
        32'h240A_0002,  // ADDIU r10, r0, 2     flushed
        32'h240B_0003,  // ADDIU r11, r0, 3     flushed
        32'hFFFF_FFFF   // HALT
    };

    // {register, value} in retire order
    logic [mips_pkg::NB_REG_ADDR+mips_pkg::LEN-1:0] expect_table [EXP_LEN] = '{
        {5'd1, 32'hFFFF_FFFB},  // -5 sign-extended
        {5'd2, 32'h0000_0005},  // 0 - (-5)
        {5'd3, 32'h0000_0001},  // -5 < 5 signed
        {5'd4, 32'h0000_0005},  // Stored word read back
        {5'd5, 32'h0000_0006},  // 5 + 1
        {5'd6, 32'h0000_0002},  // 6 & 0xFFFFFFFB
        {5'd7, 32'h0000_0002}   // 0 | 2
    };

    mips_core i_dut (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_load        (load),
        .i_load_addr   (load_addr),
        .i_load_data   (load_data),
        .o_pc          (pc),
        .o_retire_we   (retire_we),
        .o_retire_reg  (retire_reg),
        .o_retire_data (retire_data),
        .o_halt        (halt)
    );

    mips_checker u_checker (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_retire_we    (retire_we),
        .i_retire_reg   (retire_reg),
        .i_retire_data  (retire_data),
        .i_halt         (halt),
        .i_pc           (pc),
        .i_halt_pc      (HALT_PC),
        .o_error_count  (error_count),
        .o_retire_count (retire_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, the core never halted", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

    //////////////////////////////
    // Load, run and report
    //////////////////////////////
    initial begin
        int c;
        rst       = 1'b1;
        load      = 1'b0;
        load_addr = '0;
        load_data = '0;
        // Program goes in while the core sits in reset
        for (c = 0; c < RST_CYCLES; c++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (c < PROG_LEN) begin
                load      = 1'b1;
                load_addr = c[mips_pkg::NB_IM_ADDR-1:0];
                load_data = program_words[c];
            end else begin
                load = 1'b0;
            end
            if (c < EXP_LEN) begin
                u_checker.push_expect(expect_table[c][mips_pkg::NB_REG_ADDR+mips_pkg::LEN-1:
                                                      mips_pkg::LEN],
                                      expect_table[c][mips_pkg::LEN-1:0]);
            end
        end
        rst  = 1'b0;
        load = 1'b0;
        while (halt !== 1'b1) begin
            @(posedge clk);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);   // Nothing may retire after halt
        #DRIVE_DELAY;
        $display("Run finished: %0d register writes seen, %0d errors",
                 retire_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/mips_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_checker (
    input  wire                               i_clk,
    input  wire                               i_rst,
    input  wire                               i_retire_we,
    input  wire [mips_pkg::NB_REG_ADDR-1:0]   i_retire_reg,
    input  wire [mips_pkg::LEN-1:0]           i_retire_data,
    input  wire                               i_halt,
    input  wire [mips_pkg::LEN-1:0]           i_pc,
    input  wire [mips_pkg::LEN-1:0]           i_halt_pc,
    output wire [31:0]                        o_error_count,
    output wire [31:0]                        o_retire_count
);

    logic [mips_pkg::NB_REG_ADDR-1:0] exp_reg_q  [$];
    logic [mips_pkg::LEN-1:0]         exp_data_q [$];
    int   error_count  = 0;
    int   retire_count = 0;
    logic halt_seen    = 1'b0;

    assign o_error_count  = error_count;
    assign o_retire_count = retire_count;

    // One expected register write, in program order
    task automatic push_expect(
        input logic [mips_pkg::NB_REG_ADDR-1:0] reg_num,
        input logic [mips_pkg::LEN-1:0]         value
    );
        exp_reg_q.push_back(reg_num);
        exp_data_q.push_back(value);
    endtask

    //////////////////////////////
    // Retire and halt monitor
    //////////////////////////////
    always @(negedge i_clk) begin : watch_ports   // Mid-cycle, outputs settled
        logic [mips_pkg::NB_REG_ADDR-1:0] exp_reg;
        logic [mips_pkg::LEN-1:0]         exp_data;
        if (!i_rst) begin
            if ($isunknown(i_retire_we)) begin
                $display("Retire enable is unknown at %0t", $time);
                error_count++;
            end else if (i_retire_we) begin
                retire_count++;
                if (halt_seen) begin
                    $display("Register r%0d was written at %0t after the core halted",
                             i_retire_reg, $time);
                    error_count++;
                end else if (exp_reg_q.size() == 0) begin
                    $display("Register r%0d was written at %0t but no write was expected",
                             i_retire_reg, $time);
                    error_count++;
                end else begin
                    exp_reg  = exp_reg_q.pop_front();
                    exp_data = exp_data_q.pop_front();
                    if (i_retire_reg !== exp_reg) begin
                        $display("FAILED at %0t: o_retire_reg expected %0d, got %0d",
                                 $time, exp_reg, i_retire_reg);
                        error_count++;
                    end
                    if (i_retire_data !== exp_data) begin
                        $display("FAILED at %0t: o_retire_data expected 32'h%08h, got 32'h%08h",
                                 $time, exp_data, i_retire_data);
                        error_count++;
                    end
                end
            end
            // Halt must come after the last expected write
            if ((i_halt === 1'b1) && !halt_seen) begin
                halt_seen = 1'b1;
                if (exp_reg_q.size() != 0) begin
                    $display("The core halted at %0t with %0d expected writes still missing",
                             $time, exp_reg_q.size());
                    error_count++;
                end
            end
            // Fetch stays parked on the HALT word
            if ((i_halt === 1'b1) && (i_pc !== i_halt_pc)) begin
                $display("FAILED at %0t: o_pc expected 32'h%08h, got 32'h%08h",
                         $time, i_halt_pc, i_pc);
                error_count++;
            end
        end
    end

endmodule

`default_nettype wire

/* source/mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  wire                               i_clk,
    input  wire                               i_rst,
    input  wire                               i_load,
    input  wire [mips_pkg::NB_IM_ADDR-1:0]    i_load_addr,
    input  wire [mips_pkg::LEN-1:0]           i_load_data,
    output logic [mips_pkg::LEN-1:0]          o_pc,
    output logic                              o_retire_we,
    output logic [mips_pkg::NB_REG_ADDR-1:0]  o_retire_reg,
    output logic [mips_pkg::LEN-1:0]          o_retire_data,
    output logic                              o_halt
);

    // Fetch and decode
    logic [mips_pkg::LEN-1:0] if_instr, if_pc_plus4;
    logic                     id_stall;

    // ID/EX
    logic [mips_pkg::LEN-1:0]         ex_pc_plus4, ex_rs_data, ex_rt_data, ex_imm;
    logic [mips_pkg::NB_REG_ADDR-1:0] ex_rs, ex_rt, ex_dest;
    logic [mips_pkg::NB_ALU_OP-1:0]   ex_alu_op;
    logic ex_alu_src_imm, ex_reg_write, ex_mem_read, ex_mem_write, ex_branch, ex_halt;
    logic [mips_pkg::NB_FWD-1:0]      fwd_a, fwd_b;

    // EX/MEM
    logic [mips_pkg::LEN-1:0]         mem_alu_result, mem_store_data, mem_branch_target;
    logic [mips_pkg::NB_REG_ADDR-1:0] mem_dest;
    logic mem_zero, mem_reg_write, mem_mem_read, mem_mem_write, mem_branch, mem_halt;
    logic                             pc_src;

    // MEM/WB
    logic [mips_pkg::LEN-1:0]         wb_alu_result, wb_load_data, wb_data;
    logic [mips_pkg::NB_REG_ADDR-1:0] wb_dest;
    logic                             wb_reg_write, wb_mem_to_reg;

    //////////////////////////////
    // Stages
    //////////////////////////////
    instruction_fetch u_instruction_fetch (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_load          (i_load),
        .i_load_addr     (i_load_addr),
        .i_load_data     (i_load_data),
        .i_stall         (id_stall),
        .i_pc_src        (pc_src),
        .i_branch_target (mem_branch_target),
        .o_instr         (if_instr),
        .o_pc_plus4      (if_pc_plus4),
        .o_pc            (o_pc)
    );

    instruction_decode u_instruction_decode (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_instr         (if_instr),
        .i_pc_plus4      (if_pc_plus4),
        .i_flush         (pc_src),
        .i_ex_mem_read   (ex_mem_read),
        .i_ex_dest       (ex_dest),
        .i_wb_alu_result (wb_alu_result),
        .i_wb_load_data  (wb_load_data),
        .i_wb_dest       (wb_dest),
        .i_wb_reg_write  (wb_reg_write),
        .i_wb_mem_to_reg (wb_mem_to_reg),
        .o_stall         (id_stall),
        .o_wb_data       (wb_data),
        .o_pc_plus4      (ex_pc_plus4),
        .o_rs_data       (ex_rs_data),
        .o_rt_data       (ex_rt_data),
        .o_imm           (ex_imm),
        .o_rs            (ex_rs),
        .o_rt            (ex_rt),
        .o_dest          (ex_dest),
        .o_alu_op        (ex_alu_op),
        .o_alu_src_imm   (ex_alu_src_imm),
        .o_reg_write     (ex_reg_write),
        .o_mem_read      (ex_mem_read),
        .o_mem_write     (ex_mem_write),
        .o_branch        (ex_branch),
        .o_halt          (ex_halt),
        .o_retire_we     (o_retire_we),
        .o_retire_reg    (o_retire_reg)
    );

    forwarding_unit u_forwarding_unit (
        .i_rs            (ex_rs),
        .i_rt            (ex_rt),
        .i_mem_dest      (mem_dest),
        .i_mem_reg_write (mem_reg_write),
        .i_wb_dest       (wb_dest),
        .i_wb_reg_write  (wb_reg_write),
        .o_fwd_a         (fwd_a),
        .o_fwd_b         (fwd_b)
    );

    execute u_execute (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_flush         (pc_src),
        .i_pc_plus4      (ex_pc_plus4),
        .i_rs_data       (ex_rs_data),
        .i_rt_data       (ex_rt_data),
        .i_imm           (ex_imm),
        .i_dest          (ex_dest),
        .i_alu_op        (ex_alu_op),
        .i_alu_src_imm   (ex_alu_src_imm),
        .i_reg_write     (ex_reg_write),
        .i_mem_read      (ex_mem_read),
        .i_mem_write     (ex_mem_write),
        .i_branch        (ex_branch),
        .i_halt          (ex_halt),
        .i_fwd_a         (fwd_a),
        .i_fwd_b         (fwd_b),
        .i_mem_fwd_data  (mem_alu_result),
        .i_wb_fwd_data   (wb_data),
        .o_alu_result    (mem_alu_result),
        .o_store_data    (mem_store_data),
        .o_branch_target (mem_branch_target),
        .o_zero          (mem_zero),
        .o_dest          (mem_dest),
        .o_reg_write     (mem_reg_write),
        .o_mem_read      (mem_mem_read),
        .o_mem_write     (mem_mem_write),
        .o_branch        (mem_branch),
        .o_halt          (mem_halt)
    );

    memory_access u_memory_access (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_alu_result    (mem_alu_result),
        .i_store_data    (mem_store_data),
        .i_zero          (mem_zero),
        .i_dest          (mem_dest),
        .i_reg_write     (mem_reg_write),
        .i_mem_read      (mem_mem_read),
        .i_mem_write     (mem_mem_write),
        .i_branch        (mem_branch),
        .i_halt          (mem_halt),
        .o_pc_src        (pc_src),
        .o_wb_alu_result (wb_alu_result),
        .o_wb_load_data  (wb_load_data),
        .o_wb_dest       (wb_dest),
        .o_wb_reg_write  (wb_reg_write),
        .o_wb_mem_to_reg (wb_mem_to_reg),
        .o_wb_halt       (o_halt)        // Sticky MEM/WB halt bit
    );

    assign o_retire_data = wb_data;

endmodule

`default_nettype wire

/* source/memory_access.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_access (
    input  wire                               i_clk,
    input  wire                               i_rst,
    input  wire [mips_pkg::LEN-1:0]           i_alu_result,
    input  wire [mips_pkg::LEN-1:0]           i_store_data,
    input  wire                               i_zero,
    input  wire [mips_pkg::NB_REG_ADDR-1:0]   i_dest,
    input  wire                               i_reg_write,
    input  wire                               i_mem_read,
    input  wire                               i_mem_write,
    input  wire                               i_branch,
    input  wire                               i_halt,
    output logic                              o_pc_src,
    output logic [mips_pkg::LEN-1:0]          o_wb_alu_result,
    output logic [mips_pkg::LEN-1:0]          o_wb_load_data,
    output logic [mips_pkg::NB_REG_ADDR-1:0]  o_wb_dest,
    output logic                              o_wb_reg_write,
    output logic                              o_wb_mem_to_reg,
    output logic                              o_wb_halt
);

    logic [mips_pkg::LEN-1:0]        dmem [mips_pkg::DM_DEPTH];
    logic [mips_pkg::NB_DM_ADDR-1:0] word_addr;

    assign word_addr = i_alu_result[mips_pkg::NB_DM_ADDR+1:2];
    assign o_pc_src  = i_branch && i_zero;      // Taken BEQ

    always_ff @(posedge i_clk) begin
        if (i_mem_write) begin
            dmem[word_addr] <= i_store_data;
        end
    end

    //////////////////////////////
    // MEM/WB latch
    //////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_reg_write  <= 1'b0;
            o_wb_mem_to_reg <= 1'b0;
            o_wb_halt       <= 1'b0;
        end else begin
            o_wb_reg_write  <= i_reg_write;
            o_wb_mem_to_reg <= i_mem_read;
            if (i_halt) begin
                o_wb_halt <= 1'b1;              // Held until reset
            end
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb_alu_result <= i_alu_result;
        o_wb_dest       <= i_dest;
        if (i_mem_read) begin
            o_wb_load_data <= dmem[word_addr];
        end
    end

endmodule

`default_nettype wire

/* source/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  wire                               i_clk,
    input  wire                               i_rst,
    input  wire                               i_flush,
    input  wire [mips_pkg::LEN-1:0]           i_pc_plus4,
    input  wire [mips_pkg::LEN-1:0]           i_rs_data,
    input  wire [mips_pkg::LEN-1:0]           i_rt_data,
    input  wire [mips_pkg::LEN-1:0]           i_imm,
    input  wire [mips_pkg::NB_REG_ADDR-1:0]   i_dest,
    input  wire [mips_pkg::NB_ALU_OP-1:0]     i_alu_op,
    input  wire                               i_alu_src_imm,
    input  wire                               i_reg_write,
    input  wire                               i_mem_read,
    input  wire                               i_mem_write,
    input  wire                               i_branch,
    input  wire                               i_halt,
    input  wire [mips_pkg::NB_FWD-1:0]        i_fwd_a,
    input  wire [mips_pkg::NB_FWD-1:0]        i_fwd_b,
    input  wire [mips_pkg::LEN-1:0]           i_mem_fwd_data,
    input  wire [mips_pkg::LEN-1:0]           i_wb_fwd_data,
    output logic [mips_pkg::LEN-1:0]          o_alu_result,
    output logic [mips_pkg::LEN-1:0]          o_store_data,
    output logic [mips_pkg::LEN-1:0]          o_branch_target,
    output logic                              o_zero,
    output logic [mips_pkg::NB_REG_ADDR-1:0]  o_dest,
    output logic                              o_reg_write,
    output logic                              o_mem_read,
    output logic                              o_mem_write,
    output logic                              o_branch,
    output logic                              o_halt
);

    logic [mips_pkg::LEN-1:0] op_a, op_b_reg, op_b, result;

    // Operand sources
    always_comb begin
        case (i_fwd_a)
            mips_pkg::FWD_MEM: op_a = i_mem_fwd_data;
            mips_pkg::FWD_WB:  op_a = i_wb_fwd_data;
            default:           op_a = i_rs_data;
        endcase
        case (i_fwd_b)
            mips_pkg::FWD_MEM: op_b_reg = i_mem_fwd_data;
            mips_pkg::FWD_WB:  op_b_reg = i_wb_fwd_data;
            default:           op_b_reg = i_rt_data;
        endcase
    end

    assign op_b = i_alu_src_imm ? i_imm : op_b_reg;

    //////////////////////////////
    // ALU
    //////////////////////////////
    always_comb begin
        case (i_alu_op)
            mips_pkg::ALU_SUB: result = op_a - op_b;
            mips_pkg::ALU_AND: result = op_a & op_b;
            mips_pkg::ALU_OR:  result = op_a | op_b;
            mips_pkg::ALU_SLT: result = {31'd0, $signed(op_a) < $signed(op_b)};
            default:           result = op_a + op_b;
        endcase
    end

    // EX/MEM control, bubble on flush
    always_ff @(posedge i_clk) begin
        if (i_rst || i_flush) begin
            o_reg_write <= 1'b0;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
            o_branch    <= 1'b0;
            o_halt      <= 1'b0;
        end else begin
            o_reg_write <= i_reg_write;
            o_mem_read  <= i_mem_read;
            o_mem_write <= i_mem_write;
            o_branch    <= i_branch;
            o_halt      <= i_halt;
        end
    end

    always_ff @(posedge i_clk) begin
        o_alu_result    <= result;
        o_store_data    <= op_b_reg;             // Forwarded rt for SW
        o_branch_target <= i_pc_plus4 + {i_imm[mips_pkg::LEN-3:0], 2'b00};
        o_zero          <= (result == '0);
        o_dest          <= i_dest;
    end

endmodule

`default_nettype wire

/* source/instruction_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_decode (
    input  wire                               i_clk,
    input  wire                               i_rst,
    input  wire [mips_pkg::LEN-1:0]           i_instr,
    input  wire [mips_pkg::LEN-1:0]           i_pc_plus4,
    input  wire                               i_flush,
    input  wire                               i_ex_mem_read,
    input  wire [mips_pkg::NB_REG_ADDR-1:0]   i_ex_dest,
    input  wire [mips_pkg::LEN-1:0]           i_wb_alu_result,
    input  wire [mips_pkg::LEN-1:0]           i_wb_load_data,
    input  wire [mips_pkg::NB_REG_ADDR-1:0]   i_wb_dest,
    input  wire                               i_wb_reg_write,
    input  wire                               i_wb_mem_to_reg,
    output logic                              o_stall,
    output logic [mips_pkg::LEN-1:0]          o_wb_data,
    output logic [mips_pkg::LEN-1:0]          o_pc_plus4,
    output logic [mips_pkg::LEN-1:0]          o_rs_data,
    output logic [mips_pkg::LEN-1:0]          o_rt_data,
    output logic [mips_pkg::LEN-1:0]          o_imm,
    output logic [mips_pkg::NB_REG_ADDR-1:0]  o_rs,
    output logic [mips_pkg::NB_REG_ADDR-1:0]  o_rt,
    output logic [mips_pkg::NB_REG_ADDR-1:0]  o_dest,
    output logic [mips_pkg::NB_ALU_OP-1:0]    o_alu_op,
    output logic                              o_alu_src_imm,
    output logic                              o_reg_write,
    output logic                              o_mem_read,
    output logic                              o_mem_write,
    output logic                              o_branch,
    output logic                              o_halt,
    output logic                              o_retire_we,
    output logic [mips_pkg::NB_REG_ADDR-1:0]  o_retire_reg
);

    logic [mips_pkg::LEN-1:0]         regs [mips_pkg::NUM_REGS];
    logic [mips_pkg::NB_OPCODE-1:0]   opcode, funct;
    logic [mips_pkg::NB_REG_ADDR-1:0] rs, rt, rd, dest;
    logic [mips_pkg::LEN-1:0]         rs_val, rt_val, imm_ext;
    logic [mips_pkg::NB_ALU_OP-1:0]   alu_op;
    logic alu_src_imm, reg_write, mem_read, mem_write, branch, halt, uses_rt;

    assign opcode  = i_instr[31:26];
    assign rs      = i_instr[25:21];
    assign rt      = i_instr[20:16];
    assign rd      = i_instr[15:11];
    assign funct   = i_instr[5:0];
    assign imm_ext = {{16{i_instr[15]}}, i_instr[15:0]};

    //////////////////////////////
    // Control decode
    //////////////////////////////
    always_comb begin
        alu_op      = mips_pkg::ALU_ADD;
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        halt        = 1'b0;
        uses_rt     = 1'b0;
        dest        = rt;
        if (i_instr == mips_pkg::HALT_WORD) begin
            halt = 1'b1;
        end else begin
            case (opcode)
                mips_pkg::OP_RTYPE: begin
                    dest    = rd;
                    uses_rt = 1'b1;
                    reg_write = 1'b1;
                    case (funct)
                        mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                        mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                        mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                        mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                        mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                        default:           reg_write = 1'b0;  // No-op and unsupported
                    endcase
                end
                mips_pkg::OP_ADDIU: begin
                    alu_src_imm = 1'b1;
                    reg_write   = 1'b1;
                end
                mips_pkg::OP_LW: begin
                    alu_src_imm = 1'b1;
                    reg_write   = 1'b1;
                    mem_read    = 1'b1;
                end
                mips_pkg::OP_SW: begin
                    alu_src_imm = 1'b1;
                    mem_write   = 1'b1;
                end
                mips_pkg::OP_BEQ: begin
                    alu_op  = mips_pkg::ALU_SUB;    // Zero flag means equal
                    branch  = 1'b1;
                    uses_rt = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // Load-use hazard against the LW in ID/EX
    assign o_stall = i_ex_mem_read && (i_ex_dest != '0) &&
                     ((i_ex_dest == rs) || (uses_rt && (i_ex_dest == rt)));

    //////////////////////////////
    // Write-back and register file
    //////////////////////////////
    assign o_wb_data    = i_wb_mem_to_reg ? i_wb_load_data : i_wb_alu_result;
    assign o_retire_we  = i_wb_reg_write && (i_wb_dest != '0);
    assign o_retire_reg = i_wb_dest;

    always_ff @(posedge i_clk) begin
        if (o_retire_we) begin
            regs[i_wb_dest] <= o_wb_data;
        end
    end

    // Write-through so a same-cycle write is seen
    assign rs_val = (rs == '0) ? '0 :
                    (o_retire_we && (i_wb_dest == rs)) ? o_wb_data : regs[rs];
    assign rt_val = (rt == '0) ? '0 :
                    (o_retire_we && (i_wb_dest == rt)) ? o_wb_data : regs[rt];

    // ID/EX control, bubble on stall or flush
    always_ff @(posedge i_clk) begin
        if (i_rst || i_flush || o_stall) begin
            o_reg_write   <= 1'b0;
            o_mem_read    <= 1'b0;
            o_mem_write   <= 1'b0;
            o_branch      <= 1'b0;
            o_halt        <= 1'b0;
        end else begin
            o_reg_write   <= reg_write;
            o_mem_read    <= mem_read;
            o_mem_write   <= mem_write;
            o_branch      <= branch;
            o_halt        <= halt;
        end
    end

    // ID/EX payload
    always_ff @(posedge i_clk) begin
        o_pc_plus4    <= i_pc_plus4;
        o_rs_data     <= rs_val;
        o_rt_data     <= rt_val;
        o_imm         <= imm_ext;
        o_rs          <= rs;
        o_rt          <= rt;
        o_dest        <= dest;
        o_alu_op      <= alu_op;
        o_alu_src_imm <= alu_src_imm;
    end

endmodule

`default_nettype wire

/* source/instruction_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_fetch (
    input  wire                              i_clk,
    input  wire                              i_rst,
    input  wire                              i_load,
    input  wire [mips_pkg::NB_IM_ADDR-1:0]   i_load_addr,
    input  wire [mips_pkg::LEN-1:0]          i_load_data,
    input  wire                              i_stall,
    input  wire                              i_pc_src,
    input  wire [mips_pkg::LEN-1:0]          i_branch_target,
    output logic [mips_pkg::LEN-1:0]         o_instr,
    output logic [mips_pkg::LEN-1:0]         o_pc_plus4,
    output logic [mips_pkg::LEN-1:0]         o_pc
);

    logic [mips_pkg::LEN-1:0] imem [mips_pkg::IM_DEPTH];
    logic [mips_pkg::LEN-1:0] fetch_word;
    logic [mips_pkg::LEN-1:0] pc_plus4;
    logic                     fetch_halt;
    logic                     halted;       // HALT already sent down

    // Program load, works in or out of reset
    always_ff @(posedge i_clk) begin
        if (i_load) begin
            imem[i_load_addr] <= i_load_data;
        end
    end

    assign fetch_word = imem[o_pc[mips_pkg::NB_IM_ADDR+1:2]];  // Word addressed
    assign pc_plus4   = o_pc + mips_pkg::LEN'(4);
    assign fetch_halt = (fetch_word == mips_pkg::HALT_WORD);

    // PC and halt freeze
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc   <= '0;
            halted <= 1'b0;
        end else if (i_pc_src) begin
            o_pc   <= i_branch_target;
            halted <= 1'b0;                  // Flush lifts the freeze
        end else if (!i_stall) begin
            if (fetch_halt) begin
                halted <= 1'b1;
            end else begin
                o_pc <= pc_plus4;
            end
        end
    end

    //////////////////////////////
    // IF/ID latch
    //////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst || i_pc_src) begin
            o_instr <= '0;                   // All-zero word decodes as no-op
        end else if (!i_stall) begin
            o_instr <= halted ? '0 : fetch_word;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_pc_plus4 <= pc_plus4;
        end
    end

endmodule

`default_nettype wire

/* source/forwarding_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit (
    input  wire [mips_pkg::NB_REG_ADDR-1:0]  i_rs,
    input  wire [mips_pkg::NB_REG_ADDR-1:0]  i_rt,
    input  wire [mips_pkg::NB_REG_ADDR-1:0]  i_mem_dest,
    input  wire                              i_mem_reg_write,
    input  wire [mips_pkg::NB_REG_ADDR-1:0]  i_wb_dest,
    input  wire                              i_wb_reg_write,
    output logic [mips_pkg::NB_FWD-1:0]      o_fwd_a,
    output logic [mips_pkg::NB_FWD-1:0]      o_fwd_b
);

    // Youngest producer wins, r0 never forwarded
    function automatic logic [mips_pkg::NB_FWD-1:0] pick_src(
        input logic [mips_pkg::NB_REG_ADDR-1:0] src
    );
        if (i_mem_reg_write && (i_mem_dest != '0) && (i_mem_dest == src)) begin
            return mips_pkg::FWD_MEM;
        end else if (i_wb_reg_write && (i_wb_dest != '0) && (i_wb_dest == src)) begin
            return mips_pkg::FWD_WB;
        end
        return mips_pkg::FWD_REG;
    endfunction

    always_comb begin
        o_fwd_a = pick_src(i_rs);
        o_fwd_b = pick_src(i_rt);
    end

endmodule

`default_nettype wire

/* source/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // Datapath and storage sizes
    localparam int LEN         = 32;
    localparam int NB_REG_ADDR = 5;
    localparam int NUM_REGS    = 32;
    localparam int IM_DEPTH    = 64;
    localparam int NB_IM_ADDR  = 6;
    localparam int DM_DEPTH    = 64;
    localparam int NB_DM_ADDR  = 6;
    localparam int NB_OPCODE   = 6;
    localparam int NB_ALU_OP   = 3;
    localparam int NB_FWD      = 2;

    //////////////////////////////
    // Instruction encodings
    //////////////////////////////
    localparam logic [NB_OPCODE-1:0] OP_RTYPE = 6'h00;
    localparam logic [NB_OPCODE-1:0] OP_ADDIU = 6'h09;
    localparam logic [NB_OPCODE-1:0] OP_LW    = 6'h23;
    localparam logic [NB_OPCODE-1:0] OP_SW    = 6'h2B;
    localparam logic [NB_OPCODE-1:0] OP_BEQ   = 6'h04;

    localparam logic [NB_OPCODE-1:0] FN_ADDU  = 6'h21;
    localparam logic [NB_OPCODE-1:0] FN_SUBU  = 6'h23;
    localparam logic [NB_OPCODE-1:0] FN_AND   = 6'h24;
    localparam logic [NB_OPCODE-1:0] FN_OR    = 6'h25;
    localparam logic [NB_OPCODE-1:0] FN_SLT   = 6'h2A;

    localparam logic [LEN-1:0] HALT_WORD = 32'hFFFF_FFFF;

    //////////////////////////////
    // ALU and forwarding selects
    //////////////////////////////
    localparam logic [NB_ALU_OP-1:0] ALU_ADD = 3'd0;
    localparam logic [NB_ALU_OP-1:0] ALU_SUB = 3'd1;
    localparam logic [NB_ALU_OP-1:0] ALU_AND = 3'd2;
    localparam logic [NB_ALU_OP-1:0] ALU_OR  = 3'd3;
    localparam logic [NB_ALU_OP-1:0] ALU_SLT = 3'd4;

    localparam logic [NB_FWD-1:0] FWD_REG = 2'd0;  // Value read in decode
    localparam logic [NB_FWD-1:0] FWD_MEM = 2'd1;  // EX/MEM ALU result
    localparam logic [NB_FWD-1:0] FWD_WB  = 2'd2;  // Write-back data

endpackage

`default_nettype wire
